//--- rtl/mem_bus_pkg.sv
// Bus widths and the ICB command, response and SRAM word types shared by the memory subsystem
`default_nettype none

package mem_bus_pkg;

	localparam int ADDR_W  = 32;
	localparam int XLEN    = 32;
	localparam int MASK_W  = XLEN / 8;
	localparam int SRAM_DW = 16;

	// One ICB command beat
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              read;
		logic [XLEN-1:0]   wdata;
		logic [MASK_W-1:0] wmask;
	} icb_cmd_t;

	// One ICB response beat
	typedef struct packed {
		logic            err;
		logic [XLEN-1:0] rdata;
	} icb_rsp_t;

	typedef struct packed {
		logic [SRAM_DW-1:0] hi;
		logic [SRAM_DW-1:0] lo;
	} sram_half_t;

	// Bus word, or the two halfwords seen on the SRAM pins
	typedef union packed {
		logic [XLEN-1:0] word;
		sram_half_t      half;
	} sram_word_u;

endpackage

`default_nettype wire

//--- rtl/mem_map_pkg.sv
// Address map, target codes and SRAM timing defaults for the memory subsystem
`default_nettype none

package mem_map_pkg;

	////////////////////
	// Address map
	////////////////////

	// Boot ROM window 0x0000_1000 to 0x0000_1FFF
	localparam logic [31:0] MROM_BASE       = 32'h0000_1000;
	localparam int          MROM_REGION_LSB = 12;

	// External SRAM window 0x4000_0000 to 0x4FFF_FFFF
	localparam logic [31:0] SRAM_BASE       = 32'h4000_0000;
	localparam int          SRAM_REGION_LSB = 28;

	typedef enum logic [1:0] {
		TGT_MROM = 2'd0,
		TGT_SRAM = 2'd1,
		TGT_ERR  = 2'd2
	} target_e;

	// Defaults used by the top level
	localparam int MROM_DEPTH_DEF = 16;
	localparam int SRAM_AW_DEF    = 22;
	localparam int SRAM_WAIT_DEF  = 1;

endpackage

`default_nettype wire

//--- rtl/mem_cmd_router.sv
// Command side of the memory bus: accepts one ICB command, decodes its target, holds busy
`timescale 1ns/10ps
`default_nettype none

module mem_cmd_router (
	input  wire                     clk,
	input  wire                     i_reset,
	input  wire                     i_cmd_valid,
	input  mem_bus_pkg::icb_cmd_t   i_cmd,
	input  wire                     i_done,
	output logic                    o_cmd_ready,
	output logic                    o_rom_start,
	output logic                    o_sram_start,
	output logic                    o_issue,
	output mem_bus_pkg::icb_cmd_t   o_cmd,
	output mem_map_pkg::target_e    o_target
);

	import mem_bus_pkg::*;
	import mem_map_pkg::*;

	logic    busy;
	logic    fire;
	logic    hit_mrom;
	logic    hit_sram;
	target_e target;

	// Region match on the bits above each window's LSB
	assign hit_mrom = (i_cmd.addr[ADDR_W-1:MROM_REGION_LSB] ==
		MROM_BASE[ADDR_W-1:MROM_REGION_LSB]);
	assign hit_sram = (i_cmd.addr[ADDR_W-1:SRAM_REGION_LSB] ==
		SRAM_BASE[ADDR_W-1:SRAM_REGION_LSB]);

	always_comb begin
		if (hit_mrom && i_cmd.read) begin
			target = TGT_MROM;
		end else if (hit_sram) begin
			target = TGT_SRAM;
		end else begin
			// ROM writes fall here too
			target = TGT_ERR;
		end
	end

	assign o_cmd_ready  = ~busy;
	assign fire         = i_cmd_valid & o_cmd_ready;
	assign o_issue      = fire;
	assign o_target     = target;
	assign o_rom_start  = fire & (target == TGT_MROM);
	assign o_sram_start = fire & (target == TGT_SRAM);

	// One outstanding transaction
	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy <= 1'b0;
		end else if (fire) begin
			busy <= 1'b1;
		end else if (i_done) begin
			busy <= 1'b0;
		end
	end

	// Held for the SRAM sequencer while busy
	always_ff @(posedge clk) begin
		if (fire) begin
			o_cmd <= i_cmd;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mrom_ctrl.sv
// Boot ROM target loaded from mrom.hex, answers each read one cycle after its start pulse
`timescale 1ns/10ps
`default_nettype none

module mrom_ctrl #(
	parameter int MROM_DEPTH = mem_map_pkg::MROM_DEPTH_DEF
) (
	input  wire                            clk,
	input  wire                            i_reset,
	input  wire                            i_start,
	input  wire [mem_bus_pkg::ADDR_W-1:0]  i_addr,
	input  wire                            i_ack,
	output logic                           o_valid,
	output mem_bus_pkg::icb_rsp_t          o_rsp
);

	import mem_bus_pkg::*;

	localparam int IDX_W = (MROM_DEPTH > 1) ? $clog2(MROM_DEPTH) : 1;

	logic [XLEN-1:0]  rom [MROM_DEPTH];
	logic [IDX_W-1:0] idx;

	initial begin
		$readmemh("mrom.hex", rom);
	end

	// Word index wraps at the array depth
	assign idx = i_addr[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_valid <= 1'b0;
		end else if (i_start) begin
			o_valid <= 1'b1;
		end else if (i_ack) begin
			o_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_start) begin
			o_rsp <= '{err: 1'b0, rdata: rom[idx]};
		end
	end

endmodule

`default_nettype wire

//--- rtl/sram_ctrl.sv
// Asynchronous 16-bit SRAM sequencer, runs one bus word as a low then a high halfword cycle
`timescale 1ns/10ps
`default_nettype none

module sram_ctrl #(
	parameter int SRAM_AW   = mem_map_pkg::SRAM_AW_DEF,
	parameter int SRAM_WAIT = mem_map_pkg::SRAM_WAIT_DEF
) (
	input  wire                             clk,
	input  wire                             i_reset,
	input  wire                             i_start,
	input  mem_bus_pkg::icb_cmd_t           i_cmd,
	input  wire                             i_ack,
	input  wire [mem_bus_pkg::SRAM_DW-1:0]  i_sram_dq,
	output logic                            o_valid,
	output mem_bus_pkg::icb_rsp_t           o_rsp,
	output logic [SRAM_AW-1:0]              o_sram_a,
	output logic [mem_bus_pkg::SRAM_DW-1:0] o_sram_dq,
	output logic [mem_bus_pkg::SRAM_DW-1:0] o_sram_dq_t,
	output logic                            o_sram_cen,
	output logic                            o_sram_oen,
	output logic                            o_sram_wen,
	output logic [1:0]                      o_sram_ben
);

	import mem_bus_pkg::*;

	localparam int CNT_W = (SRAM_WAIT > 0) ? $clog2(SRAM_WAIT + 1) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LO,
		ST_HI,
		ST_RSP
	} state_e;

	state_e             state;
	logic [CNT_W-1:0]   cnt;
	logic               active;
	logic               phase;
	logic               phase_end;
	logic [ADDR_W-2:0]  half_addr;
	sram_word_u         rd_word;
	sram_word_u         wr_word;

	assign active    = (state == ST_LO) || (state == ST_HI);
	assign phase     = (state == ST_HI);
	assign phase_end = active && (cnt == CNT_W'(SRAM_WAIT));

	////////////////////
	// Sequencer
	////////////////////

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= ST_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state <= ST_LO;
						cnt   <= '0;
					end
				end
				ST_LO, ST_HI: begin
					if (phase_end) begin
						cnt   <= '0;
						state <= phase ? ST_RSP : ST_HI;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_RSP: begin
					if (i_ack) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Read data sampled on the last cycle of each phase
	always_ff @(posedge clk) begin
		if (phase_end && i_cmd.read) begin
			if (phase) begin
				rd_word.half.hi <= i_sram_dq;
			end else begin
				rd_word.half.lo <= i_sram_dq;
			end
		end
	end

	////////////////////
	// SRAM pins
	////////////////////

	// Halfword address is word index times two plus phase
	assign half_addr    = {i_cmd.addr[ADDR_W-1:2], phase};
	assign o_sram_a     = half_addr[SRAM_AW-1:0];
	assign wr_word.word = i_cmd.wdata;
	assign o_sram_dq    = phase ? wr_word.half.hi : wr_word.half.lo;

	assign o_sram_cen  = ~active;
	assign o_sram_oen  = ~(active & i_cmd.read);
	assign o_sram_wen  = ~(active & ~i_cmd.read);
	assign o_sram_dq_t = (active & ~i_cmd.read) ? '0 : '1;

	always_comb begin
		if (!active) begin
			o_sram_ben = 2'b11;
		end else if (i_cmd.read) begin
			// Both lanes on a read
			o_sram_ben = 2'b00;
		end else begin
			o_sram_ben = phase ? ~i_cmd.wmask[3:2] : ~i_cmd.wmask[1:0];
		end
	end

	assign o_valid = (state == ST_RSP);
	assign o_rsp   = '{err: 1'b0, rdata: i_cmd.read ? rd_word.word : '0};

endmodule

`default_nettype wire

//--- rtl/mem_rsp_merge.sv
// Response side of the memory bus: picks the pending target's response and drives the ICB port
`timescale 1ns/10ps
`default_nettype none

module mem_rsp_merge (
	input  wire                    clk,
	input  wire                    i_reset,
	input  wire                    i_issue,
	input  mem_map_pkg::target_e   i_target,
	input  wire                    i_rom_valid,
	input  mem_bus_pkg::icb_rsp_t  i_rom_rsp,
	input  wire                    i_sram_valid,
	input  mem_bus_pkg::icb_rsp_t  i_sram_rsp,
	input  wire                    i_rsp_ready,
	output logic                   o_rom_ack,
	output logic                   o_sram_ack,
	output logic                   o_done,
	output logic                   o_rsp_valid,
	output mem_bus_pkg::icb_rsp_t  o_rsp
);

	import mem_map_pkg::*;

	target_e pend_tgt;
	logic    err_valid;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			pend_tgt  <= TGT_ERR;
			err_valid <= 1'b0;
		end else begin
			if (i_issue) begin
				pend_tgt <= i_target;
			end
			// Local error response, one cycle after issue
			if (i_issue && (i_target == TGT_ERR)) begin
				err_valid <= 1'b1;
			end else if (o_done && (pend_tgt == TGT_ERR)) begin
				err_valid <= 1'b0;
			end
		end
	end

	always_comb begin
		case (pend_tgt)
			TGT_MROM: begin
				o_rsp_valid = i_rom_valid;
				o_rsp       = i_rom_rsp;
			end
			TGT_SRAM: begin
				o_rsp_valid = i_sram_valid;
				o_rsp       = i_sram_rsp;
			end
			default: begin
				o_rsp_valid = err_valid;
				o_rsp       = '{err: 1'b1, rdata: '0};
			end
		endcase
	end

	assign o_done     = o_rsp_valid & i_rsp_ready;
	assign o_rom_ack  = o_done & (pend_tgt == TGT_MROM);
	assign o_sram_ack = o_done & (pend_tgt == TGT_SRAM);

endmodule

`default_nettype wire

//--- rtl/mem_subsys.sv
// Memory subsystem top level, ICB port into the boot ROM and the external SRAM pins
`timescale 1ns/10ps
`default_nettype none

module mem_subsys #(
	parameter int MROM_DEPTH = mem_map_pkg::MROM_DEPTH_DEF,
	parameter int SRAM_AW    = mem_map_pkg::SRAM_AW_DEF,
	parameter int SRAM_WAIT  = mem_map_pkg::SRAM_WAIT_DEF
) (
	input  wire                             clk,
	input  wire                             i_reset,
	input  wire                             i_cmd_valid,
	output logic                            o_cmd_ready,
	input  mem_bus_pkg::icb_cmd_t           i_cmd,
	output logic                            o_rsp_valid,
	input  wire                             i_rsp_ready,
	output mem_bus_pkg::icb_rsp_t           o_rsp,
	output logic [SRAM_AW-1:0]              o_sram_a,
	output logic [mem_bus_pkg::SRAM_DW-1:0] o_sram_dq,
	input  wire  [mem_bus_pkg::SRAM_DW-1:0] i_sram_dq,
	output logic [mem_bus_pkg::SRAM_DW-1:0] o_sram_dq_t,
	output logic                            o_sram_cen,
	output logic                            o_sram_oen,
	output logic                            o_sram_wen,
	output logic [1:0]                      o_sram_ben
);

	import mem_bus_pkg::*;
	import mem_map_pkg::*;

	icb_cmd_t cmd_q;
	target_e  target;
	icb_rsp_t rom_rsp;
	icb_rsp_t sram_rsp;
	logic     rom_start;
	logic     sram_start;
	logic     issue;
	logic     done;
	logic     rom_valid;
	logic     rom_ack;
	logic     sram_valid;
	logic     sram_ack;

	mem_cmd_router u_router (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_cmd_valid  (i_cmd_valid),
		.i_cmd        (i_cmd),
		.i_done       (done),
		.o_cmd_ready  (o_cmd_ready),
		.o_rom_start  (rom_start),
		.o_sram_start (sram_start),
		.o_issue      (issue),
		.o_cmd        (cmd_q),
		.o_target     (target)
	);

	// ROM samples the address on the accepting edge
	mrom_ctrl #(
		.MROM_DEPTH (MROM_DEPTH)
	) u_mrom (
		.clk     (clk),
		.i_reset (i_reset),
		.i_start (rom_start),
		.i_addr  (i_cmd.addr),
		.i_ack   (rom_ack),
		.o_valid (rom_valid),
		.o_rsp   (rom_rsp)
	);

	sram_ctrl #(
		.SRAM_AW   (SRAM_AW),
		.SRAM_WAIT (SRAM_WAIT)
	) u_sram (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_start     (sram_start),
		.i_cmd       (cmd_q),
		.i_ack       (sram_ack),
		.i_sram_dq   (i_sram_dq),
		.o_valid     (sram_valid),
		.o_rsp       (sram_rsp),
		.o_sram_a    (o_sram_a),
		.o_sram_dq   (o_sram_dq),
		.o_sram_dq_t (o_sram_dq_t),
		.o_sram_cen  (o_sram_cen),
		.o_sram_oen  (o_sram_oen),
		.o_sram_wen  (o_sram_wen),
		.o_sram_ben  (o_sram_ben)
	);

	mem_rsp_merge u_merge (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_issue      (issue),
		.i_target     (target),
		.i_rom_valid  (rom_valid),
		.i_rom_rsp    (rom_rsp),
		.i_sram_valid (sram_valid),
		.i_sram_rsp   (sram_rsp),
		.i_rsp_ready  (i_rsp_ready),
		.o_rom_ack    (rom_ack),
		.o_sram_ack   (sram_ack),
		.o_done       (done),
		.o_rsp_valid  (o_rsp_valid),
		.o_rsp        (o_rsp)
	);

endmodule

`default_nettype wire

//--- tb/mem_subsys_props.sv
// Protocol properties for the memory subsystem top level, attached to mem_subsys with bind
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_props (
	input wire                             clk,
	input wire                             i_reset,
	input wire                             i_cmd_valid,
	input wire                             o_cmd_ready,
	input mem_bus_pkg::icb_cmd_t           i_cmd,
	input wire                             o_rsp_valid,
	input wire                             i_rsp_ready,
	input mem_bus_pkg::icb_rsp_t           o_rsp,
	input wire [mem_bus_pkg::SRAM_DW-1:0]  o_sram_dq_t,
	input wire                             o_sram_cen,
	input wire                             o_sram_oen,
	input wire                             o_sram_wen,
	input wire [1:0]                       o_sram_ben
);

	import mem_bus_pkg::*;
	import mem_map_pkg::*;

	// Property failures so far
	int   fail_cnt = 0;
	logic sram_pend;
	logic sram_idle;
	logic hit_sram;

	assign hit_sram  = (i_cmd.addr[ADDR_W-1:SRAM_REGION_LSB] ==
		SRAM_BASE[ADDR_W-1:SRAM_REGION_LSB]);
	assign sram_idle = o_sram_cen && o_sram_oen && o_sram_wen &&
		(o_sram_ben == 2'b11) && (o_sram_dq_t == '1);

	// Own view of whether the pending transaction targets the SRAM
	always_ff @(posedge clk) begin
		if (i_reset) begin
			sram_pend <= 1'b0;
		end else if (i_cmd_valid && o_cmd_ready) begin
			sram_pend <= hit_sram;
		end else if (o_rsp_valid && i_rsp_ready) begin
			sram_pend <= 1'b0;
		end
	end

	////////////////////
	// Handshake rules
	////////////////////

	p_reset_state: assert property (@(posedge clk)
		i_reset |=> !o_rsp_valid && o_cmd_ready && sram_idle)
	else begin
		$error("Port or SRAM pins not idle after reset");
		fail_cnt++;
	end

	p_rsp_hold: assert property (@(posedge clk) disable iff (i_reset)
		o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
	else begin
		$error("Response dropped or changed while stalled");
		fail_cnt++;
	end

	p_busy_rsp: assert property (@(posedge clk) disable iff (i_reset)
		o_rsp_valid |-> !o_cmd_ready)
	else begin
		$error("Command port ready while a response is pending");
		fail_cnt++;
	end

	p_busy_set: assert property (@(posedge clk) disable iff (i_reset)
		i_cmd_valid && o_cmd_ready |=> !o_cmd_ready)
	else begin
		$error("Command port stayed ready after accepting a command");
		fail_cnt++;
	end

	// Busy lasts until the response handshake
	p_busy_hold: assert property (@(posedge clk) disable iff (i_reset)
		!o_cmd_ready && !(o_rsp_valid && i_rsp_ready) |=> !o_cmd_ready)
	else begin
		$error("Command port ready again before the response handshake");
		fail_cnt++;
	end

	p_busy_clr: assert property (@(posedge clk) disable iff (i_reset)
		o_rsp_valid && i_rsp_ready |=> o_cmd_ready)
	else begin
		$error("Command port not ready after the response handshake");
		fail_cnt++;
	end

	////////////////////
	// SRAM pins
	////////////////////

	// ROM and error transactions leave the SRAM alone
	p_sram_quiet: assert property (@(posedge clk) disable iff (i_reset)
		!sram_pend |-> sram_idle)
	else begin
		$error("SRAM pins active with no SRAM access pending");
		fail_cnt++;
	end

	p_bus_drive: assert property (@(posedge clk) disable iff (i_reset)
		!o_sram_cen && !o_sram_wen |-> o_sram_dq_t == '0)
	else begin
		$error("SRAM data bus not driven during a write");
		fail_cnt++;
	end

	p_bus_release: assert property (@(posedge clk) disable iff (i_reset)
		!o_sram_oen |-> o_sram_dq_t == '1)
	else begin
		$error("SRAM data bus not released during a read");
		fail_cnt++;
	end

endmodule

`default_nettype wire

//--- tb/tb_mem_subsys.sv
// Testbench for the memory subsystem, runs ROM, SRAM and error traffic and checks each response
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys;

	import mem_bus_pkg::*;
	import mem_map_pkg::*;

	localparam int SRAM_WORDS = 512;
	localparam int SRAM_LAT   = 2 * (SRAM_WAIT_DEF + 1) + 1;
	localparam int WAIT_MAX   = 50;

	logic                   clk;
	logic                   i_reset;
	logic                   i_cmd_valid;
	icb_cmd_t               i_cmd;
	logic                   i_rsp_ready;
	logic                   o_cmd_ready;
	logic                   o_rsp_valid;
	icb_rsp_t               o_rsp;
	logic [SRAM_AW_DEF-1:0] o_sram_a;
	logic [SRAM_DW-1:0]     o_sram_dq;
	logic [SRAM_DW-1:0]     o_sram_dq_t;
	logic [SRAM_DW-1:0]     i_sram_dq;
	logic                   o_sram_cen;
	logic                   o_sram_oen;
	logic                   o_sram_wen;
	logic [1:0]             o_sram_ben;

	logic [XLEN-1:0]    rom_image [MROM_DEPTH_DEF];
	logic [SRAM_DW-1:0] sram_mem [1024];
	logic [XLEN-1:0]    shadow [SRAM_WORDS];
	int                 err_cnt;
	int                 timeout_cnt;

	mem_subsys #(
		.MROM_DEPTH (MROM_DEPTH_DEF),
		.SRAM_AW    (SRAM_AW_DEF),
		.SRAM_WAIT  (SRAM_WAIT_DEF)
	) u_mem_subsys (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_cmd_valid (i_cmd_valid),
		.o_cmd_ready (o_cmd_ready),
		.i_cmd       (i_cmd),
		.o_rsp_valid (o_rsp_valid),
		.i_rsp_ready (i_rsp_ready),
		.o_rsp       (o_rsp),
		.o_sram_a    (o_sram_a),
		.o_sram_dq   (o_sram_dq),
		.i_sram_dq   (i_sram_dq),
		.o_sram_dq_t (o_sram_dq_t),
		.o_sram_cen  (o_sram_cen),
		.o_sram_oen  (o_sram_oen),
		.o_sram_wen  (o_sram_wen),
		.o_sram_ben  (o_sram_ben)
	);

	bind mem_subsys mem_subsys_props u_props (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_cmd_valid (i_cmd_valid),
		.o_cmd_ready (o_cmd_ready),
		.i_cmd       (i_cmd),
		.o_rsp_valid (o_rsp_valid),
		.i_rsp_ready (i_rsp_ready),
		.o_rsp       (o_rsp),
		.o_sram_dq_t (o_sram_dq_t),
		.o_sram_cen  (o_sram_cen),
		.o_sram_oen  (o_sram_oen),
		.o_sram_wen  (o_sram_wen),
		.o_sram_ben  (o_sram_ben)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Power-up contents, unique per halfword address
	function automatic logic [SRAM_DW-1:0] fill_half(input int h);
		return 16'(h * 37 + 'h1234);
	endfunction

	////////////////////
	// SRAM pin model
	////////////////////

	assign i_sram_dq = (!o_sram_oen && !o_sram_cen) ? sram_mem[o_sram_a[9:0]] : '0;

	always @(posedge clk) begin
		if (i_reset) begin
			for (int h = 0; h < 1024; h++) begin
				sram_mem[10'(h)] <= fill_half(h);
			end
		end else if (!o_sram_cen && !o_sram_wen) begin
			if (!o_sram_ben[0]) begin
				sram_mem[o_sram_a[9:0]][7:0] <= o_sram_dq[7:0];
			end
			if (!o_sram_ben[1]) begin
				sram_mem[o_sram_a[9:0]][15:8] <= o_sram_dq[15:8];
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// One command, then its response; entered and left just after a rising edge
	task automatic run_xact(input logic [ADDR_W-1:0] addr, input logic rd,
		input logic [XLEN-1:0] wdata, input logic [MASK_W-1:0] wmask,
		input int exp_lat, input icb_rsp_t exp_rsp);
		int   waited;
		int   lat;
		int   stall;
		logic bp;

		bp    = ($urandom % 4) == 0;
		stall = int'($urandom % 6) + 1;
		i_cmd_valid <= 1'b1;
		i_cmd       <= '{addr: addr, read: rd, wdata: wdata, wmask: wmask};
		i_rsp_ready <= ~bp;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!o_cmd_ready && waited < WAIT_MAX);
		i_cmd_valid <= 1'b0;
		if (!o_cmd_ready) begin
			$display("Timeout: command to 0x%08h was never accepted", addr);
			timeout_cnt++;
			return;
		end
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!o_rsp_valid && lat < WAIT_MAX);
		if (!o_rsp_valid) begin
			$display("Timeout: no response for the command to 0x%08h", addr);
			timeout_cnt++;
			return;
		end
		check_value("response latency", 32'(lat), 32'(exp_lat));
		check_value("o_rsp.err", {31'b0, o_rsp.err}, {31'b0, exp_rsp.err});
		check_value("o_rsp.rdata", o_rsp.rdata, exp_rsp.rdata);
		if (bp) begin
			// Stalled response must still be there afterwards
			repeat (stall) @(posedge clk);
			i_rsp_ready <= 1'b1;
			@(posedge clk);
			check_value("o_rsp_valid", {31'b0, o_rsp_valid}, 32'h1);
			check_value("o_rsp.rdata", o_rsp.rdata, exp_rsp.rdata);
		end
	endtask

	task automatic rom_read(input logic [ADDR_W-1:0] addr);
		logic [3:0] idx;
		icb_rsp_t   exp;

		idx       = 4'((addr / 4) % MROM_DEPTH_DEF);
		exp.err   = 1'b0;
		exp.rdata = rom_image[idx];
		run_xact(addr, 1'b1, '0, '0, 1, exp);
	endtask

	task automatic sram_read(input logic [8:0] widx);
		icb_rsp_t exp;

		exp.err   = 1'b0;
		exp.rdata = shadow[widx];
		run_xact(SRAM_BASE | {21'b0, widx, 2'b00}, 1'b1, '0, '0, SRAM_LAT, exp);
	endtask

	task automatic sram_write(input logic [8:0] widx, input logic [XLEN-1:0] data,
		input logic [MASK_W-1:0] mask);
		logic [XLEN-1:0] bm;
		icb_rsp_t        exp;

		bm = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
		shadow[widx] = (shadow[widx] & ~bm) | (data & bm);
		exp.err   = 1'b0;
		exp.rdata = '0;
		run_xact(SRAM_BASE | {21'b0, widx, 2'b00}, 1'b0, data, mask, SRAM_LAT, exp);
	endtask

	task automatic err_access(input logic [ADDR_W-1:0] addr, input logic rd);
		icb_rsp_t exp;

		exp.err   = 1'b1;
		exp.rdata = '0;
		run_xact(addr, rd, $urandom, 4'hf, 1, exp);
	endtask

	initial begin
		logic [31:0] rnd;
		logic [8:0]  widx;
		int          prop_fails;

		i_reset     <= 1'b1;
		i_cmd_valid <= 1'b0;
		i_cmd       <= '0;
		i_rsp_ready <= 1'b1;
		err_cnt     = 0;
		timeout_cnt = 0;
		void'($urandom(32'h2a3c8d98));
		$readmemh("mrom.hex", rom_image);
		for (int w = 0; w < SRAM_WORDS; w++) begin
			shadow[9'(w)] = {fill_half(2 * w + 1), fill_half(2 * w)};
		end
		repeat (5) @(posedge clk);
		i_reset <= 1'b0;
		@(posedge clk);

		// ROM sweep, then random offsets across the window
		for (int i = 0; i < MROM_DEPTH_DEF; i++) begin
			rom_read(MROM_BASE + 32'(i * 4));
		end
		for (int i = 0; i < 24; i++) begin
			rnd = $urandom;
			rom_read({MROM_BASE[31:12], rnd[11:2], 2'b00});
		end

		// Untouched SRAM words, then a write and read mix on a small set
		for (int i = 0; i < 8; i++) begin
			sram_read(9'($urandom));
		end
		for (int i = 0; i < 80; i++) begin
			widx = ($urandom % 4 == 0) ? 9'($urandom) : 9'($urandom % 32);
			if ($urandom % 2 == 0) begin
				sram_write(widx, $urandom, 4'($urandom));
			end else begin
				sram_read(widx);
			end
		end

		// ROM writes and unmapped addresses
		for (int i = 0; i < 8; i++) begin
			rnd = $urandom;
			err_access({MROM_BASE[31:12], rnd[11:2], 2'b00}, 1'b0);
			err_access({rnd[31:28] | 4'h8, rnd[27:0]}, rnd[0]);
		end
		err_access(32'h0000_0ffc, 1'b1);
		err_access(32'h0000_2000, 1'b1);
		err_access(32'h3fff_fffc, 1'b0);
		err_access(32'h5000_0000, 1'b1);

		// Targets interleaved
		for (int i = 0; i < 30; i++) begin
			rnd = $urandom;
			case (rnd % 3)
				0: rom_read({MROM_BASE[31:12], rnd[13:4], 2'b00});
				1: sram_read(9'(rnd % 32));
				default: err_access({4'h2, rnd[27:0]}, rnd[1]);
			endcase
		end

		repeat (4) @(posedge clk);
		prop_fails = u_mem_subsys.u_props.fail_cnt;
		$display("Check errors: %0d, property failures: %0d, timeouts: %0d",
			err_cnt, prop_fails, timeout_cnt);
		if (err_cnt == 0 && prop_fails == 0 && timeout_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
rtl/mem_bus_pkg.sv
rtl/mem_map_pkg.sv
rtl/mem_cmd_router.sv
rtl/mrom_ctrl.sv
rtl/sram_ctrl.sv
rtl/mem_rsp_merge.sv
rtl/mem_subsys.sv
tb/mem_subsys_props.sv
tb/tb_mem_subsys.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mem_subsys
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Regression passed

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- mrom.hex
// Boot ROM image: one 32-bit word per line, word 0 sits at 0x0000_1000
00000297
02028593
f1402573
0182a283
00028067
0000006f
40000000
deadbeef
00100513
00a12023
30200073
10500073
c0ffee01
5a5aa5a5
0badf00d
12345678
